// File: hdl/mem_pkg.sv
package mem_pkg;

    localparam int XLEN          = 32;
    localparam int REG_AW        = 5;
    localparam int EXC_IN_W      = 5;
    localparam int EXC_OUT_W     = 6;  // bit 0 is ale, upper bits from execute
    localparam int NUM_LANES_DEF = 2;

    typedef enum logic [3:0] {
        MEM_NONE,
        LD_B,
        LD_BU,
        LD_H,
        LD_HU,
        LD_W,
        LL_W,   // plain word load here
        ST_B,
        ST_H,
        ST_W
    } mem_op_e;

    function automatic logic is_load(mem_op_e op);
        return op inside {LD_B, LD_BU, LD_H, LD_HU, LD_W, LL_W};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {ST_B, ST_H, ST_W};
    endfunction

    function automatic logic misaligned(mem_op_e op, logic [XLEN-1:0] addr);
        case (op)
            LD_H, LD_HU, ST_H: begin
                return addr[0];
            end
            LD_W, LL_W, ST_W: begin
                return |addr[1:0];
            end
            default: begin
                return 1'b0;  // bytes and non-memory ops
            end
        endcase
    endfunction

endpackage

// File: hdl/lane_access_if.sv
`timescale 1ns/1ps

interface lane_access_if
    import mem_pkg::*;
();

    logic            req;    // held until done
    mem_op_e         op;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic            done;   // one-cycle pulse
    logic [XLEN-1:0] rdata;  // already aligned and extended

    modport bundle (
        output req,
        output op,
        output addr,
        output wdata,
        input  done,
        input  rdata
    );

    modport seq (
        input  req,
        input  op,
        input  addr,
        input  wdata,
        output done,
        output rdata
    );

endinterface

// File: hdl/load_align.sv
`timescale 1ns/1ps

module load_align
    import mem_pkg::*;
(
    input  mem_op_e         op,
    input  logic [1:0]      offset,
    input  logic [XLEN-1:0] raw,
    output logic [XLEN-1:0] data
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    always_comb begin
        case (offset)
            2'b00: begin
                byte_sel = raw[7:0];
            end
            2'b01: begin
                byte_sel = raw[15:8];
            end
            2'b10: begin
                byte_sel = raw[23:16];
            end
            default: begin
                byte_sel = raw[31:24];
            end
        endcase
    end

    assign half_sel = offset[1] ? raw[31:16] : raw[15:0];  // bit 0 clear for legal halves

    always_comb begin
        case (op)
            LD_B: begin
                data = {{(XLEN-8){byte_sel[7]}}, byte_sel};
            end
            LD_BU: begin
                data = {{(XLEN-8){1'b0}}, byte_sel};
            end
            LD_H: begin
                data = {{(XLEN-16){half_sel[15]}}, half_sel};
            end
            LD_HU: begin
                data = {{(XLEN-16){1'b0}}, half_sel};
            end
            default: begin
                data = raw;  // word loads
            end
        endcase
    end

endmodule

// File: hdl/mem_bundle_reg.sv
`timescale 1ns/1ps

module mem_bundle_reg
    import mem_pkg::*;
#(
    parameter int NUM_LANES = NUM_LANES_DEF
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                in_valid,
    input  mem_op_e [NUM_LANES-1:0]             in_op,
    input  logic [NUM_LANES-1:0][XLEN-1:0]      in_addr,
    input  logic [NUM_LANES-1:0][XLEN-1:0]      in_wdata,
    input  logic [NUM_LANES-1:0]                in_rd_we,
    input  logic [NUM_LANES-1:0][REG_AW-1:0]    in_rd_addr,
    input  logic [NUM_LANES-1:0][XLEN-1:0]      in_rd_data,
    input  logic [NUM_LANES-1:0][EXC_IN_W-1:0]  in_excp,
    output logic                                pause_mem,
    output logic                                wb_valid,
    output logic [NUM_LANES-1:0]                wb_we,
    output logic [NUM_LANES-1:0][REG_AW-1:0]    wb_addr,
    output logic [NUM_LANES-1:0][XLEN-1:0]      wb_data,
    output logic [NUM_LANES-1:0][EXC_OUT_W-1:0] commit_excp,
    lane_access_if.bundle                       acc
);

    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic                                busy;
    logic                                accept;
    logic [NUM_LANES-1:0]                ale;
    logic [NUM_LANES-1:0]                live_d;
    logic [NUM_LANES-1:0]                pend_d;
    logic [NUM_LANES-1:0]                live_q;
    logic [NUM_LANES-1:0]                pending_q;
    logic [LANE_W-1:0]                   sel;

    mem_op_e [NUM_LANES-1:0]             op_q;
    logic [NUM_LANES-1:0][XLEN-1:0]      addr_q;
    logic [NUM_LANES-1:0][XLEN-1:0]      wdata_q;
    logic [NUM_LANES-1:0]                rd_we_q;
    logic [NUM_LANES-1:0][REG_AW-1:0]    rd_addr_q;
    logic [NUM_LANES-1:0][XLEN-1:0]      rd_data_q;  // load result replaces it
    logic [NUM_LANES-1:0][EXC_OUT_W-1:0] excp_q;

    assign accept = in_valid & ~busy;

    // an exception in any lane kills it and every lane above
    always_comb begin
        logic exc_seen;
        exc_seen = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            ale[i]    = misaligned(in_op[i], in_addr[i]);
            exc_seen  = exc_seen | ale[i] | (|in_excp[i]);
            live_d[i] = ~exc_seen;
            pend_d[i] = live_d[i] & (is_load(in_op[i]) | is_store(in_op[i]));
        end
    end

    always_comb begin
        sel = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                sel = LANE_W'(i);  // lowest pending wins
            end
        end
    end

    assign acc.req   = |pending_q;
    assign acc.op    = op_q[sel];
    assign acc.addr  = addr_q[sel];
    assign acc.wdata = wdata_q[sel];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            pending_q <= '0;
            live_q    <= '0;
        end else if (accept) begin
            busy      <= 1'b1;
            pending_q <= pend_d;
            live_q    <= live_d;
        end else begin
            if (wb_valid) begin
                busy <= 1'b0;  // released after the wb pulse
            end
            if (acc.done) begin
                pending_q[sel] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q      <= in_op;
            addr_q    <= in_addr;
            wdata_q   <= in_wdata;
            rd_we_q   <= in_rd_we;
            rd_addr_q <= in_rd_addr;
            rd_data_q <= in_rd_data;
            for (int i = 0; i < NUM_LANES; i++) begin
                excp_q[i] <= {in_excp[i], ale[i]};
            end
        end else if (acc.done && is_load(acc.op)) begin
            rd_data_q[sel] <= acc.rdata;
        end
    end

    assign pause_mem   = busy;
    assign wb_valid    = busy & ~(|pending_q);
    assign wb_we       = {NUM_LANES{wb_valid}} & live_q & rd_we_q;
    assign wb_addr     = rd_addr_q;
    assign wb_data     = rd_data_q;
    assign commit_excp = excp_q;

endmodule

// File: hdl/dcache_seq.sv
`timescale 1ns/1ps

module dcache_seq
    import mem_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            dc_addr_ok,
    input  logic            dc_data_ok,
    input  logic [XLEN-1:0] dc_rdata,
    output logic            dc_req,
    output logic            dc_wr,
    output logic [XLEN-1:0] dc_addr,
    output logic [3:0]      dc_wstrb,
    output logic [XLEN-1:0] dc_wdata,
    lane_access_if.seq      acc
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA
    } state_e;

    state_e state;
    state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (acc.req) begin
                    state_nxt = ADDR;
                end
            end
            ADDR: begin
                if (dc_addr_ok) begin
                    state_nxt = DATA;  // request taken
                end
            end
            DATA: begin
                if (dc_data_ok) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign dc_req  = (state == ADDR);
    assign dc_wr   = is_store(acc.op);
    assign dc_addr = {acc.addr[XLEN-1:2], 2'b00};

    // byte lanes follow the low address bits
    always_comb begin
        case (acc.op)
            ST_B: begin
                dc_wstrb = 4'b0001 << acc.addr[1:0];
                dc_wdata = {4{acc.wdata[7:0]}};
            end
            ST_H: begin
                dc_wstrb = acc.addr[1] ? 4'b1100 : 4'b0011;
                dc_wdata = {2{acc.wdata[15:0]}};
            end
            ST_W: begin
                dc_wstrb = 4'b1111;
                dc_wdata = acc.wdata;
            end
            default: begin
                dc_wstrb = 4'b0000;  // loads
                dc_wdata = acc.wdata;
            end
        endcase
    end

    assign acc.done = (state == DATA) & dc_data_ok;

    load_align load_align_i (
        .op     (acc.op),
        .offset (acc.addr[1:0]),
        .raw    (dc_rdata),
        .data   (acc.rdata)
    );

endmodule

// File: hdl/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top
    import mem_pkg::*;
#(
    parameter int NUM_LANES = NUM_LANES_DEF
) (
    input  logic                                clk,
    input  logic                                arst_n,

    input  logic                                in_valid,
    input  mem_op_e [NUM_LANES-1:0]             in_op,
    input  logic [NUM_LANES-1:0][XLEN-1:0]      in_addr,
    input  logic [NUM_LANES-1:0][XLEN-1:0]      in_wdata,
    input  logic [NUM_LANES-1:0]                in_rd_we,
    input  logic [NUM_LANES-1:0][REG_AW-1:0]    in_rd_addr,
    input  logic [NUM_LANES-1:0][XLEN-1:0]      in_rd_data,
    input  logic [NUM_LANES-1:0][EXC_IN_W-1:0]  in_excp,
    output logic                                pause_mem,  // to pipeline control

    output logic                                dc_req,
    output logic                                dc_wr,
    output logic [XLEN-1:0]                     dc_addr,
    output logic [3:0]                          dc_wstrb,
    output logic [XLEN-1:0]                     dc_wdata,
    input  logic                                dc_addr_ok,
    input  logic                                dc_data_ok,
    input  logic [XLEN-1:0]                     dc_rdata,

    output logic                                wb_valid,
    output logic [NUM_LANES-1:0]                wb_we,
    output logic [NUM_LANES-1:0][REG_AW-1:0]    wb_addr,
    output logic [NUM_LANES-1:0][XLEN-1:0]      wb_data,
    output logic [NUM_LANES-1:0][EXC_OUT_W-1:0] commit_excp
);

    lane_access_if acc_if ();

    mem_bundle_reg #(
        .NUM_LANES (NUM_LANES)
    ) mem_bundle_reg_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .in_addr     (in_addr),
        .in_wdata    (in_wdata),
        .in_rd_we    (in_rd_we),
        .in_rd_addr  (in_rd_addr),
        .in_rd_data  (in_rd_data),
        .in_excp     (in_excp),
        .pause_mem   (pause_mem),
        .wb_valid    (wb_valid),
        .wb_we       (wb_we),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .commit_excp (commit_excp),
        .acc         (acc_if.bundle)
    );

    dcache_seq dcache_seq_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .dc_addr_ok (dc_addr_ok),
        .dc_data_ok (dc_data_ok),
        .dc_rdata   (dc_rdata),
        .dc_req     (dc_req),
        .dc_wr      (dc_wr),
        .dc_addr    (dc_addr),
        .dc_wstrb   (dc_wstrb),
        .dc_wdata   (dc_wdata),
        .acc        (acc_if.seq)
    );

endmodule

// File: dv/dcache_model.sv
`timescale 1ns/1ps

module dcache_model
    import mem_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            dc_req,
    input  logic            dc_wr,
    input  logic [XLEN-1:0] dc_addr,
    input  logic [3:0]      dc_wstrb,
    input  logic [XLEN-1:0] dc_wdata,
    output logic            dc_addr_ok,
    output logic            dc_data_ok,
    output logic [XLEN-1:0] dc_rdata,
    output int              req_count
);

    logic [XLEN-1:0] mem [0:255];  // preloaded by the testbench
    logic [31:0]     lcg_state;

    function automatic int next_delay(int span);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[31:16]) % span;  // upper bits, the low ones cycle fast
    endfunction

    initial begin
        logic            wr;
        logic [7:0]      idx;
        logic [3:0]      strb;
        logic [XLEN-1:0] wdata;
        int              wait_n;
        lcg_state  = 32'hf50ec440;
        dc_addr_ok = 1'b0;
        dc_data_ok = 1'b0;
        dc_rdata   = '0;
        req_count  = 0;
        forever begin
            @(posedge clk);
            #2;
            if (arst_n && dc_req) begin
                wait_n = next_delay(4);
                repeat (wait_n) begin
                    @(posedge clk);
                    #2;
                end
                dc_addr_ok = 1'b1;
                wr         = dc_wr;
                idx        = dc_addr[9:2];
                strb       = dc_wstrb;
                wdata      = dc_wdata;
                req_count++;
                @(posedge clk);
                #2;
                dc_addr_ok = 1'b0;
                wait_n     = next_delay(3);  // one cycle already gone
                repeat (wait_n) begin
                    @(posedge clk);
                    #2;
                end
                if (wr) begin
                    for (int b = 0; b < 4; b++) begin
                        if (strb[b]) begin
                            mem[idx][8*b +: 8] = wdata[8*b +: 8];
                        end
                    end
                end else begin
                    dc_rdata = mem[idx];
                end
                dc_data_ok = 1'b1;
                @(posedge clk);
                #2;
                dc_data_ok = 1'b0;
            end
        end
    end

endmodule

// File: dv/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb
    import mem_pkg::*;
();

    localparam int NL      = NUM_LANES_DEF;
    localparam int TIMEOUT = 200;  // cycles per wait

    logic                         clk;
    logic                         arst_n;
    logic                         in_valid;
    mem_op_e [NL-1:0]             in_op;
    logic [NL-1:0][XLEN-1:0]      in_addr, in_wdata, in_rd_data;
    logic [NL-1:0]                in_rd_we;
    logic [NL-1:0][REG_AW-1:0]    in_rd_addr;
    logic [NL-1:0][EXC_IN_W-1:0]  in_excp;
    logic                         pause_mem;
    logic                         dc_req, dc_wr, dc_addr_ok, dc_data_ok;
    logic [XLEN-1:0]              dc_addr, dc_wdata, dc_rdata;
    logic [3:0]                   dc_wstrb;
    logic                         wb_valid;
    logic [NL-1:0]                wb_we;
    logic [NL-1:0][REG_AW-1:0]    wb_addr;
    logic [NL-1:0][XLEN-1:0]      wb_data;
    logic [NL-1:0][EXC_OUT_W-1:0] commit_excp;
    int                           req_count;

    // next bundle, and what writeback should show for it
    mem_op_e [NL-1:0]             s_op;
    logic [NL-1:0][XLEN-1:0]      s_addr, s_wdata, s_rd_data;
    logic [NL-1:0]                s_rd_we;
    logic [NL-1:0][REG_AW-1:0]    s_rd_addr;
    logic [NL-1:0][EXC_IN_W-1:0]  s_excp;
    logic [NL-1:0]                exp_we;
    logic [NL-1:0][REG_AW-1:0]    exp_addr;
    logic [NL-1:0][XLEN-1:0]      exp_data;
    logic [NL-1:0][EXC_OUT_W-1:0] exp_excp;
    logic                         exp_armed;
    logic [XLEN-1:0]              shadow [0:255];

    int    cycle = 0;
    int    test_errors;
    int    total_errors;
    int    tests_run;
    int    tests_failed;
    string test_name;

    mem_stage_top #(.NUM_LANES(NL)) mem_stage_top_i (.*);
    dcache_model dcache_model_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [XLEN-1:0] fill_word(int idx);
        logic [7:0] a;
        a = idx[7:0];
        return {a ^ 8'ha5, a, ~a, a + 8'h3c};  // both sign cases in every word
    endfunction

    function automatic int access_size(mem_op_e op);
        case (op)
            LD_B, LD_BU, ST_B: return 1;
            LD_H, LD_HU, ST_H: return 2;
            default:           return 4;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] expect_load(mem_op_e op, logic [XLEN-1:0] word,
                                                    logic [1:0] off);
        logic [XLEN-1:0] shifted;
        shifted = word >> (8 * off);
        case (op)
            LD_B:    return {{24{shifted[7]}}, shifted[7:0]};
            LD_BU:   return {24'h0, shifted[7:0]};
            LD_H:    return {{16{shifted[15]}}, shifted[15:0]};
            LD_HU:   return {16'h0, shifted[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] merge_store(mem_op_e op, logic [XLEN-1:0] old,
                                                    logic [XLEN-1:0] wdata, logic [1:0] off);
        logic [XLEN-1:0] mask;
        case (op)
            ST_B:    mask = 32'h0000_00ff << (8 * off);
            ST_H:    mask = 32'h0000_ffff << (8 * off);
            default: mask = 32'hffff_ffff;
        endcase
        return (old & ~mask) | ((wdata << (8 * off)) & mask);
    endfunction

    // expected writeback of the staged bundle; returns the number of cache accesses
    function automatic int predict_bundle();
        logic       exc_seen;
        logic       ale;
        logic       live;
        logic [7:0] idx;
        int         accesses;
        exc_seen = 1'b0;
        accesses = 0;
        for (int i = 0; i < NL; i++) begin
            ale         = misaligned(s_op[i], s_addr[i]);
            exc_seen    = exc_seen | ale | (|s_excp[i]);
            live        = ~exc_seen;
            idx         = s_addr[i][9:2];
            exp_excp[i] = {s_excp[i], ale};
            exp_we[i]   = live & s_rd_we[i];
            exp_addr[i] = s_rd_addr[i];
            exp_data[i] = s_rd_data[i];
            if (live && is_load(s_op[i])) begin
                exp_data[i] = expect_load(s_op[i], shadow[idx], s_addr[i][1:0]);
                accesses++;
            end
            if (live && is_store(s_op[i])) begin
                shadow[idx] = merge_store(s_op[i], shadow[idx], s_wdata[i], s_addr[i][1:0]);
                accesses++;
            end
        end
        return accesses;
    endfunction

    task automatic report_mismatch(string sig, int lane, logic [XLEN-1:0] exp_v,
                                   logic [XLEN-1:0] got_v);
        $display("FAIL t=%0t %s[%0d] exp=%h got=%h", $time, sig, lane, exp_v, got_v);
        test_errors++;
    endtask

    always @(negedge clk) begin
        if (arst_n === 1'b1 && wb_valid === 1'b1) begin
            if (!exp_armed) begin
                $display("wb_valid at %0t with no bundle outstanding", $time);
                test_errors++;
            end else begin
                for (int i = 0; i < NL; i++) begin
                    assert (wb_we[i] === exp_we[i])
                        else report_mismatch("wb_we", i, exp_we[i], wb_we[i]);
                    assert (wb_addr[i] === exp_addr[i])
                        else report_mismatch("wb_addr", i, exp_addr[i], wb_addr[i]);
                    assert (wb_data[i] === exp_data[i])
                        else report_mismatch("wb_data", i, exp_data[i], wb_data[i]);
                    assert (commit_excp[i] === exp_excp[i])
                        else report_mismatch("commit_excp", i, exp_excp[i], commit_excp[i]);
                end
            end
            exp_armed = 1'b0;
        end
    end

    task automatic set_lane(int lane, mem_op_e op, logic [XLEN-1:0] addr,
                            logic [XLEN-1:0] wdata, logic [EXC_IN_W-1:0] excp);
        s_op[lane]      = op;
        s_addr[lane]    = addr;
        s_wdata[lane]   = wdata;
        s_rd_we[lane]   = 1'b1;
        s_rd_addr[lane] = REG_AW'(addr[6:2] + lane + 1);
        s_rd_data[lane] = {addr[15:0], 16'hd00d} ^ lane;  // easy to spot if not replaced
        s_excp[lane]    = excp;
    endtask

    task automatic run_bundle(input logic hold_valid, input int want_latency);
        int timer;
        int reqs_before;
        int exp_reqs;
        int accept_cycle;
        timer = 0;
        @(posedge clk);
        #2;
        while (pause_mem && timer < TIMEOUT) begin
            @(posedge clk);
            #2;
            timer++;
        end
        if (pause_mem) begin
            $display("stage still busy after %0d cycles, bundle not sent", TIMEOUT);
            test_errors++;
            return;
        end
        in_valid    = 1'b1;
        in_op       = s_op;
        in_addr     = s_addr;
        in_wdata    = s_wdata;
        in_rd_we    = s_rd_we;
        in_rd_addr  = s_rd_addr;
        in_rd_data  = s_rd_data;
        in_excp     = s_excp;
        reqs_before = req_count;
        exp_reqs    = predict_bundle();
        exp_armed   = 1'b1;
        @(posedge clk);
        #2;
        accept_cycle = cycle;
        if (hold_valid) begin
            for (int i = 0; i < NL; i++) begin
                in_op[i] = MEM_NONE;  // another bundle knocking
            end
            in_rd_data = ~s_rd_data;
        end else begin
            in_valid = 1'b0;
        end
        timer = 0;
        while (!wb_valid && timer < TIMEOUT) begin
            assert (pause_mem === 1'b1)
                else report_mismatch("pause_mem", 0, 1, pause_mem);
            @(posedge clk);
            #2;
            timer++;
        end
        in_valid = 1'b0;
        if (!wb_valid) begin
            $display("no wb_valid within %0d cycles of acceptance", TIMEOUT);
            test_errors++;
            exp_armed = 1'b0;
            return;
        end
        assert (pause_mem === 1'b1)
            else report_mismatch("pause_mem", 0, 1, pause_mem);
        if (want_latency > 0) begin
            assert (cycle - accept_cycle + 1 == want_latency)
                else report_mismatch("wb_valid latency", 0, want_latency,
                                     cycle - accept_cycle + 1);
        end
        @(negedge clk);
        #1;
        assert (req_count - reqs_before == exp_reqs)
            else report_mismatch("dc_req count", 0, exp_reqs, req_count - reqs_before);
    endtask

    task automatic start_test(string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d error(s)", test_name, test_errors);
        end
    endtask

    task automatic check_reset_state();
        start_test("reset state");
        assert (pause_mem === 1'b0) else report_mismatch("pause_mem", 0, 0, pause_mem);
        assert (wb_valid === 1'b0) else report_mismatch("wb_valid", 0, 0, wb_valid);
        assert (wb_we === '0) else report_mismatch("wb_we", 0, 0, wb_we);
        assert (dc_req === 1'b0) else report_mismatch("dc_req", 0, 0, dc_req);
        finish_test();
    endtask

    task automatic check_loads();
        mem_op_e ops [6];
        ops = '{LD_B, LD_BU, LD_H, LD_HU, LD_W, LL_W};
        start_test("load widths and offsets");
        for (int k = 0; k < 6; k++) begin
            for (int off = 0; off < 4; off += access_size(ops[k])) begin
                set_lane(0, ops[k], 32'h040 + 16 * k + off, '0, '0);
                set_lane(1, ops[k], 32'h240 + 16 * k + off, '0, '0);
                run_bundle(1'b0, 0);
            end
        end
        finish_test();
    endtask

    task automatic check_stores();
        mem_op_e ops [3];
        ops = '{ST_B, ST_H, ST_W};
        start_test("store strobes and read back");
        for (int k = 0; k < 3; k++) begin
            for (int off = 0; off < 4; off += access_size(ops[k])) begin
                set_lane(0, ops[k], 32'h100 + 16 * k + off, 32'h8c3e_7f01 + 32'h1111 * off + k, '0);
                set_lane(1, LD_W, 32'h100 + 16 * k, '0, '0);  // same word, lane order
                run_bundle(1'b0, 0);
            end
        end
        finish_test();
    endtask

    task automatic check_misaligned();
        start_test("misaligned accesses");
        set_lane(0, LD_H, 32'h201, '0, '0);
        set_lane(1, LD_W, 32'h204, '0, '0);
        run_bundle(1'b0, 1);
        set_lane(0, LD_BU, 32'h205, '0, '0);
        set_lane(1, ST_W, 32'h206, 32'hffff_ffff, '0);
        run_bundle(1'b0, 0);
        set_lane(0, ST_H, 32'h303, 32'h1234_5678, '0);
        set_lane(1, LD_HU, 32'h30a, '0, '0);
        run_bundle(1'b0, 1);
        finish_test();
    endtask

    task automatic check_cancel();
        start_test("lane 0 exception cancels lane 1");
        set_lane(0, LD_W, 32'h080, '0, 5'b00100);
        set_lane(1, ST_W, 32'h084, 32'hdead_beef, '0);
        run_bundle(1'b0, 1);
        set_lane(0, MEM_NONE, 32'h088, '0, 5'b10001);
        set_lane(1, LD_B, 32'h08d, '0, 5'b00010);
        run_bundle(1'b0, 1);
        finish_test();
    endtask

    task automatic check_random_delays();
        mem_op_e ops [8];
        int      off;
        ops = '{ST_H, LD_B, ST_B, LD_W, ST_W, LD_HU, LL_W, LD_H};
        start_test("two lanes under random cache delays");
        for (int k = 0; k < 8; k++) begin
            off = (3 * k) % 4;
            off = off - off % access_size(ops[k]);
            set_lane(0, ops[k], 32'h180 + 4 * k + off, 32'h3b9a_ca00 ^ (32'h0101_0101 * k), '0);
            set_lane(1, (k % 2) ? LD_W : LD_H, 32'h180 + 4 * ((k + 3) % 8), '0, '0);
            run_bundle(1'b1, 0);
        end
        finish_test();
    endtask

    task automatic check_passthrough();
        start_test("no memory op passes through");
        for (int k = 0; k < 2; k++) begin
            set_lane(0, MEM_NONE, 32'h3c0 + k, '0, '0);
            set_lane(1, MEM_NONE, 32'h3c4 + k, '0, '0);
            s_rd_we[1] = k[0];
            run_bundle(1'b0, 1);
        end
        finish_test();
    endtask

    initial begin
        arst_n       = 1'b0;
        in_valid     = 1'b0;
        in_addr      = '0;
        in_wdata     = '0;
        in_rd_we     = '0;
        in_rd_addr   = '0;
        in_rd_data   = '0;
        in_excp      = '0;
        exp_armed    = 1'b0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < NL; i++) begin
            in_op[i] = MEM_NONE;
        end
        for (int i = 0; i < 256; i++) begin
            shadow[i]             = fill_word(i);
            dcache_model_i.mem[i] = shadow[i];
        end
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;
        check_reset_state();
        check_loads();
        check_stores();
        check_misaligned();
        check_cancel();
        check_random_delays();
        check_passthrough();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: project.f
hdl/mem_pkg.sv
hdl/lane_access_if.sv
hdl/load_align.sv
hdl/mem_bundle_reg.sv
hdl/dcache_seq.sv
hdl/mem_stage_top.sv
dv/dcache_model.sv
dv/mem_stage_tb.sv
